//--- include/ps2_defs.svh
// --------------------------------------------------------------------
// Scan-code set 2 prefix byte values shared by the RTL package and
// the testbench.
// --------------------------------------------------------------------
`ifndef PS2_DEFS_SVH
`define PS2_DEFS_SVH

// Prefix sent ahead of an extended key code.
`define PS2_PREFIX_EXT   8'hE0
// Prefix sent ahead of a key release code.
`define PS2_PREFIX_BREAK 8'hF0

`endif

//--- rtl/ps2_pkg.sv
// --------------------------------------------------------------------
// Common types for the PS/2 keyboard receiver.
// Vector typedefs, FSM state enums and protocol constants.
// --------------------------------------------------------------------
`default_nettype none

`include "ps2_defs.svh"

package ps2_pkg;

    // One scan-code byte as sent by the keyboard.
    typedef logic [7:0] scan_byte_t;
    // One raw PS/2 frame with the start bit in bit 0.
    typedef logic [10:0] frame_t;
    // Saturating count of rejected frames.
    typedef logic [3:0] err_count_t;

    // Start, eight data bits, odd parity and stop.
    localparam int FRAME_BITS = 11;

    // Set 2 prefix bytes.
    localparam scan_byte_t PREFIX_EXT   = `PS2_PREFIX_EXT;
    localparam scan_byte_t PREFIX_BREAK = `PS2_PREFIX_BREAK;

    // Frame receiver FSM.
    typedef enum logic {RX_IDLE, RX_SHIFT} rx_state_t;
    // Prefix tracking FSM of the decoder.
    typedef enum logic [1:0] {DEC_BASE, DEC_EXT, DEC_BREAK} dec_state_t;
    // Host handshake FSM.
    typedef enum logic [1:0] {PORT_IDLE, PORT_REQ, PORT_WAIT_LOW} port_state_t;

endpackage

`default_nettype wire

//--- rtl/ps2_byte_if.sv
// --------------------------------------------------------------------
// Byte channel from the frame receiver to the scan-code decoder.
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface ps2_byte_if;
    import ps2_pkg::*;

    // Single-cycle strobe for each finished frame.
    // There is no ready, the keyboard cannot be held off.
    logic       valid;
    scan_byte_t data;
    // Set when the odd parity check failed.
    logic       parity_err;
    // Set when the stop bit was sampled low.
    logic       framing_err;

    // Frame receiver side.
    modport rx (output valid, data, parity_err, framing_err);
    // Decoder side.
    modport dec (input valid, data, parity_err, framing_err);

endinterface

`default_nettype wire

//--- rtl/key_event_if.sv
// --------------------------------------------------------------------
// Key event channel from the decoder to the host port.
// Valid/ready transfer, data held stable until taken.
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

interface key_event_if;
    import ps2_pkg::*;

    logic       valid;
    logic       ready;
    // Key code with prefixes removed.
    scan_byte_t code;
    // An E0 prefix came before the code.
    logic       extended;
    // An F0 prefix came before the code.
    logic       release_key;

    // Decoder side drives the event.
    modport src (output valid, code, extended, release_key, input ready);
    // Host port side accepts it.
    modport sink (input valid, code, extended, release_key, output ready);

endinterface

`default_nettype wire

//--- rtl/ps2_frame_rx.sv
// --------------------------------------------------------------------
// PS/2 frame receiver.
// Line synchronizers, keyboard clock edge detect, 11-bit shifter and
// the parity and stop bit checks.
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ps2_frame_rx (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   ps2_clk,
    input  logic   ps2_data,
    ps2_byte_if.rx out
);
    import ps2_pkg::*;

    logic [1:0] clk_sync;
    logic [1:0] data_sync;
    logic       clk_prev;
    logic       clk_fall;
    rx_state_t  state;
    logic [3:0] bit_cnt;
    frame_t     shift_reg;
    frame_t     frame_next;
    logic       frame_done;

    // ----------------------------------------------------------------
    // Synchronizers and edge detect
    // ----------------------------------------------------------------

    // Both lines idle high, so the flops come out of reset high.
    // This keeps a false falling edge from appearing after reset.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
        end
    end

    // High for one cycle after the synchronized clock went low.
    // The FSM acts on it at the next edge, the third after the pin fell.
    assign clk_fall = clk_prev & ~clk_sync[1];

    // Bits arrive LSB first, so each new bit enters at the top.
    // After eleven shifts the start bit sits in bit 0.
    assign frame_next = {data_sync[1], shift_reg[FRAME_BITS-1:1]};

    // The stop bit is the last of the frame.
    assign frame_done = clk_fall && (state == RX_SHIFT) &&
                        (bit_cnt == 4'(FRAME_BITS - 1));

    // ----------------------------------------------------------------
    // Frame FSM
    // ----------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RX_IDLE;
            bit_cnt   <= 4'd0;
            out.valid <= 1'b0;
        end else begin
            out.valid <= frame_done;
            if (clk_fall) begin
                case (state)
                    RX_IDLE: begin
                        // A low data line on a clock fall is a start bit.
                        if (!data_sync[1]) begin
                            state   <= RX_SHIFT;
                            bit_cnt <= 4'd1;
                        end
                    end
                    RX_SHIFT: begin
                        if (frame_done) begin
                            state   <= RX_IDLE;
                            bit_cnt <= 4'd0;
                        end else begin
                            bit_cnt <= bit_cnt + 4'd1;
                        end
                    end
                    default: state <= RX_IDLE;
                endcase
            end
        end
    end

    // The shifter runs on every fall, in idle too.
    // Whatever it holds before the start bit is pushed out by the frame.
    always_ff @(posedge clk) begin
        if (clk_fall) begin
            shift_reg <= frame_next;
        end
        if (frame_done) begin
            out.data        <= frame_next[8:1];
            // Data and parity together must hold an odd number of ones.
            out.parity_err  <= ~^frame_next[9:1];
            out.framing_err <= ~frame_next[10];
        end
    end

    // One strobe per frame, frames are far apart in system cycles.
    assert property (@(posedge clk) disable iff (!rst_n)
        out.valid |=> !out.valid);

endmodule

`default_nettype wire

//--- rtl/scan_code_decoder.sv
// --------------------------------------------------------------------
// Scan-code set 2 decoder.
// Folds E0 and F0 prefixes into key events, holds one pending event,
// and counts bad frames.
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module scan_code_decoder (
    input  logic                clk,
    input  logic                rst_n,
    ps2_byte_if.dec             bytes,
    key_event_if.src            events,
    output logic                overflow,
    output ps2_pkg::err_count_t error_count
);
    import ps2_pkg::*;

    dec_state_t state;
    logic       ext_seen;
    logic       byte_bad;
    logic       byte_code;
    logic       slot_free;

    // A frame that failed either check carries no usable byte.
    assign byte_bad = bytes.valid & (bytes.parity_err | bytes.framing_err);

    // Any good byte that is not a prefix completes a key event.
    // E1 lands here as well and is passed on as a plain code.
    assign byte_code = bytes.valid & ~byte_bad &
                       (bytes.data != PREFIX_EXT) & (bytes.data != PREFIX_BREAK);

    // The output register is the one pending slot.
    // It is free when empty or when its event leaves this cycle.
    assign slot_free = ~events.valid | events.ready;

    // ----------------------------------------------------------------
    // Prefix tracking and error count
    // ----------------------------------------------------------------

    // DEC_EXT marks a pending E0, DEC_BREAK a pending F0.
    // ext_seen keeps the E0 across the F0 of an extended release.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state       <= DEC_BASE;
            ext_seen    <= 1'b0;
            error_count <= '0;
        end else if (bytes.valid) begin
            if (byte_bad) begin
                // Forget any prefix so the next code comes out plain.
                state    <= DEC_BASE;
                ext_seen <= 1'b0;
                if (error_count != '1) begin
                    error_count <= error_count + 4'd1;
                end
            end else if (bytes.data == PREFIX_EXT) begin
                state    <= DEC_EXT;
                ext_seen <= 1'b1;
            end else if (bytes.data == PREFIX_BREAK) begin
                state <= DEC_BREAK;
            end else begin
                state    <= DEC_BASE;
                ext_seen <= 1'b0;
            end
        end
    end

    // ----------------------------------------------------------------
    // Pending event and overflow
    // ----------------------------------------------------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            events.valid <= 1'b0;
            overflow     <= 1'b0;
        end else begin
            if (byte_code && slot_free) begin
                events.valid <= 1'b1;
            end else if (events.ready) begin
                events.valid <= 1'b0;
            end
            // The keyboard cannot wait, so a full slot loses the event.
            if (byte_code && !slot_free) begin
                overflow <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_code && slot_free) begin
            events.code        <= bytes.data;
            events.extended    <= ext_seen;
            events.release_key <= (state == DEC_BREAK);
        end
    end

    // A held event must not change until the port takes it.
    assert property (@(posedge clk) disable iff (!rst_n)
        events.valid && !events.ready |=> events.valid &&
        $stable({events.code, events.extended, events.release_key}));

endmodule

`default_nettype wire

//--- rtl/key_event_port.sv
// --------------------------------------------------------------------
// Host port with the four-phase req/ack exchange and the LED register.
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module key_event_port (
    input  logic                clk,
    input  logic                rst_n,
    key_event_if.sink           events,
    output logic                ev_req,
    input  logic                ev_ack,
    output ps2_pkg::scan_byte_t ev_code,
    output logic                ev_extended,
    output logic                ev_release,
    output ps2_pkg::scan_byte_t leds
);
    import ps2_pkg::*;

    port_state_t state;
    logic        take;

    // Events are only taken once the previous exchange has fully ended.
    assign events.ready = (state == PORT_IDLE);
    assign take         = events.valid & events.ready;

    // req is decoded straight from the state flops.
    assign ev_req = (state == PORT_REQ);

    // PORT_REQ waits for ack to rise, PORT_WAIT_LOW for it to fall.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= PORT_IDLE;
            leds  <= '0;
        end else begin
            case (state)
                PORT_IDLE: begin
                    if (take) begin
                        state <= PORT_REQ;
                        // Make and release codes both show on the LEDs.
                        leds  <= events.code;
                    end
                end
                PORT_REQ: begin
                    if (ev_ack) begin
                        state <= PORT_WAIT_LOW;
                    end
                end
                PORT_WAIT_LOW: begin
                    if (!ev_ack) begin
                        state <= PORT_IDLE;
                    end
                end
                default: state <= PORT_IDLE;
            endcase
        end
    end

    // Latched event data, stable for the whole exchange.
    always_ff @(posedge clk) begin
        if (take) begin
            ev_code     <= events.code;
            ev_extended <= events.extended;
            ev_release  <= events.release_key;
        end
    end

    // A new request only starts after the host has dropped ack.
    assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ev_req) |-> !ev_ack);

endmodule

`default_nettype wire

//--- rtl/ps2_keyboard_top.sv
// --------------------------------------------------------------------
// PS/2 keyboard receiver top level.
// Frame receiver, scan-code decoder and host port in a chain.
// --------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

module ps2_keyboard_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                ps2_clk,
    input  logic                ps2_data,
    output logic                ev_req,
    input  logic                ev_ack,
    output ps2_pkg::scan_byte_t ev_code,
    output logic                ev_extended,
    output logic                ev_release,
    output logic                overflow,
    output ps2_pkg::err_count_t error_count,
    output ps2_pkg::scan_byte_t leds
);

    // Internal channels between the three blocks.
    ps2_byte_if  byte_bus ();
    key_event_if event_bus ();

    ps2_frame_rx i_frame_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .ps2_clk  (ps2_clk),
        .ps2_data (ps2_data),
        .out      (byte_bus)
    );

    scan_code_decoder i_decoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .bytes       (byte_bus),
        .events      (event_bus),
        .overflow    (overflow),
        .error_count (error_count)
    );

    key_event_port i_port (
        .clk         (clk),
        .rst_n       (rst_n),
        .events      (event_bus),
        .ev_req      (ev_req),
        .ev_ack      (ev_ack),
        .ev_code     (ev_code),
        .ev_extended (ev_extended),
        .ev_release  (ev_release),
        .leds        (leds)
    );

endmodule

`default_nettype wire

//--- bench/ps2_keyboard_tb.sv
// ----------------------------------------------------------------------
// Testbench for the PS/2 keyboard receiver.
// Sends PS/2 frames from the step table, plays the four-phase host
// and checks events, LEDs, overflow and the error count.
// ----------------------------------------------------------------------
`timescale 1ns/100ps
`default_nettype none

`include "ps2_defs.svh"

module ps2_keyboard_tb;

    logic       clk;
    logic       rst_n;
    logic       ps2_clk;
    logic       ps2_data;
    logic       ev_req;
    logic       ev_ack = 1'b0;
    logic [7:0] ev_code;
    logic       ev_extended;
    logic       ev_release;
    logic       overflow;
    logic [3:0] error_count;
    logic [7:0] leds;

    // Events as {extended, release, code}, expected and seen by the host.
    logic [9:0]  exp_q [$];
    logic [9:0]  got_q [$];
    logic [9:0]  held;
    int          errors = 0;
    int          hold_cycles;
    int          host_phase = 0;
    int          host_cnt;
    logic [31:0] rng;

    ps2_keyboard_top i_ps2_keyboard_top (
        .clk(clk), .rst_n(rst_n), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
        .ev_req(ev_req), .ev_ack(ev_ack), .ev_code(ev_code),
        .ev_extended(ev_extended), .ev_release(ev_release),
        .overflow(overflow), .error_count(error_count), .leds(leds)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        errors++;
    endtask

    // One frame, LSB first, with 10 system cycles per PS/2 half period.
    // err_kind 1 flips the parity bit, 2 pulls the stop bit low.
    task automatic send_frame(input logic [7:0] value, input int err_kind);
        logic [10:0] frame;
        int          i;
        frame = {1'b1, ~^value, value, 1'b0};
        if (err_kind == 1) frame[9] = ~frame[9];
        if (err_kind == 2) frame[10] = 1'b0;
        for (i = 0; i < 11; i++) begin
            @(negedge clk);
            ps2_data = frame[i];
            repeat (10) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (10) @(negedge clk);
            ps2_clk = 1'b1;
        end
        @(negedge clk);
        ps2_data = 1'b1;
        repeat (20) @(negedge clk);
    endtask

    // ------------------------------------------------------------------
    // Host side of the four-phase exchange
    // ------------------------------------------------------------------

    // Phase 0 waits for req, 1 holds ack low, 2 has raised ack.
    always @(negedge clk) begin
        if (!rst_n) begin
            host_phase <= 0;
            ev_ack     <= 1'b0;
        end else if (host_phase == 0) begin
            if (ev_req) begin
                held <= {ev_extended, ev_release, ev_code};
                got_q.push_back({ev_extended, ev_release, ev_code});
                // The LEDs load on the same edge that raises req.
                if (leds !== ev_code) report_mismatch("leds", leds, ev_code);
                if (ev_code == `PS2_PREFIX_EXT || ev_code == `PS2_PREFIX_BREAK) begin
                    $display("Prefix byte %0h was delivered as a key event", ev_code);
                    errors++;
                end
                rng = next_random(rng);
                host_cnt   <= (hold_cycles != 0) ? hold_cycles : int'(rng[3:0]);
                host_phase <= 1;
            end
        end else if (host_phase == 1) begin
            if (!ev_req) begin
                $display("ev_req fell at %0t before ev_ack was raised", $time);
                errors++;
                host_phase <= 0;
            end else if ({ev_extended, ev_release, ev_code} !== held) begin
                report_mismatch("{ev_extended,ev_release,ev_code}",
                                {ev_extended, ev_release, ev_code}, held);
            end else if (host_cnt == 0) begin
                ev_ack     <= 1'b1;
                host_phase <= 2;
            end else begin
                host_cnt <= host_cnt - 1;
            end
        end else begin
            // req must be gone one edge after ack rose.
            if (ev_req) report_mismatch("ev_req", ev_req, 1'b0);
            ev_ack     <= 1'b0;
            host_phase <= 0;
        end
    end

    // ------------------------------------------------------------------
    // Step table
    // ------------------------------------------------------------------

    initial begin : stimulus
        int          fd;
        int          n_fields;
        int          kind;
        int          count;
        int          data [3];
        int          err_kind;
        int          hold;
        int          e_code;
        int          e_ext;
        int          e_rel;
        int          e_ovf;
        int          e_errs;
        int          steps;
        int          i;
        int          t;
        logic        timed_out;
        logic [9:0]  want;
        logic [9:0]  seen;
        logic [7:0]  last_code;
        string       line;
        clk = 1'b0;
        rst_n = 1'b0;
        ps2_clk = 1'b1;
        ps2_data = 1'b1;
        hold_cycles = 0;
        rng = 32'h7bcac97c;
        steps = 0;
        timed_out = 1'b0;
        last_code = 8'd0;
        repeat (10) @(negedge clk);
        if (ev_req !== 1'b0) report_mismatch("ev_req", ev_req, 0);
        if (overflow !== 1'b0) report_mismatch("overflow", overflow, 0);
        if (error_count !== 4'd0) report_mismatch("error_count", error_count, 0);
        if (leds !== 8'd0) report_mismatch("leds", leds, 0);
        rst_n = 1'b1;
        fd = $fopen("bench/ps2_tests.txt", "r");
        if (fd == 0) begin
            $display("Could not open the step table bench/ps2_tests.txt");
            errors++;
        end else begin
            while (!timed_out && $fgets(line, fd) != 0) begin
                n_fields = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h",
                                   kind, count, data[0], data[1], data[2], err_kind,
                                   hold, e_code, e_ext, e_rel, e_ovf, e_errs);
                // Comment and blank lines do not give all twelve columns.
                if (n_fields == 12) begin
                    steps++;
                    hold_cycles = hold;
                    for (i = 0; i < count; i++) begin
                        send_frame(data[i][7:0], (i == count - 1) ? err_kind : 0);
                    end
                    if (kind != 1) exp_q.push_back({e_ext[0], e_rel[0], e_code[7:0]});
                    if (kind != 2) begin
                        for (t = 0; t < 4000 && got_q.size() < exp_q.size(); t++) begin
                            @(negedge clk);
                        end
                        if (got_q.size() < exp_q.size()) begin
                            $display("Step %0d timed out waiting for a key event", steps);
                            errors++;
                            timed_out = 1'b1;
                        end else begin
                            // Well past the few cycles a late event would need.
                            repeat (40) @(negedge clk);
                            while (exp_q.size() > 0 && got_q.size() > 0) begin
                                want = exp_q.pop_front();
                                seen = got_q.pop_front();
                                last_code = want[7:0];
                                if (seen !== want) report_mismatch("key event", seen, want);
                            end
                            if (got_q.size() > 0) begin
                                $display("Step %0d saw a key event that should not exist",
                                         steps);
                                errors++;
                                got_q.delete();
                            end
                            // Dropped events and bad frames leave the LEDs alone.
                            if (leds !== last_code) report_mismatch("leds", leds, last_code);
                            if (overflow !== e_ovf[0]) report_mismatch("overflow", overflow, e_ovf);
                            if (error_count !== e_errs[3:0]) begin
                                report_mismatch("error_count", error_count, e_errs);
                            end
                        end
                    end
                end
            end
            $fclose(fd);
        end
        $display("Summary: %0d steps run, %0d errors", steps, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/ps2_tests.txt
# kind count b0 b1 b2 err hold code ext rel ovf errs, all in hex
# kind 0 checks one event, 1 checks no event, 2 queues one; err 1 parity, 2 stop
0 1 1C 00 00 0 0 1C 0 0 0 0
0 2 F0 1C 00 0 0 1C 0 1 0 0
0 2 E0 75 00 0 0 75 1 0 0 0
0 3 E0 F0 75 0 0 75 1 1 0 0
0 1 E1 00 00 0 0 E1 0 0 0 0
0 1 29 00 00 0 28 29 0 0 0 0
0 3 E0 F0 6B 0 3C 6B 1 1 0 0
1 1 2B 00 00 1 0 00 0 0 0 1
1 1 2B 00 00 2 0 00 0 0 0 2
1 2 E0 4A 00 1 0 00 0 0 0 3
0 1 4A 00 00 0 0 4A 0 0 0 3
1 2 F0 33 00 2 0 00 0 0 0 4
0 1 33 00 00 0 0 33 0 0 0 4
# Host holds ack off across three key events, the third is lost.
2 1 1C 00 00 0 3E8 1C 0 0 0 4
2 2 F0 32 00 0 3E8 32 0 1 0 4
1 1 21 00 00 0 0 00 0 0 1 4
0 1 5A 00 00 0 0 5A 0 0 1 4
0 2 E0 11 00 0 0 11 1 0 1 4

//--- list.f
+incdir+include
rtl/ps2_pkg.sv
rtl/ps2_byte_if.sv
rtl/key_event_if.sv
rtl/ps2_frame_rx.sv
rtl/scan_code_decoder.sv
rtl/key_event_port.sv
rtl/ps2_keyboard_top.sv
bench/ps2_keyboard_tb.sv

//--- Bender.yml
package:
  name: ps2_keyboard

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/ps2_pkg.sv
      - rtl/ps2_byte_if.sv
      - rtl/key_event_if.sv
      - rtl/ps2_frame_rx.sv
      - rtl/scan_code_decoder.sv
      - rtl/key_event_port.sv
      - rtl/ps2_keyboard_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/ps2_keyboard_tb.sv
